// File: hdl/rv_pkg.sv
package rv_pkg;

	parameter int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;

	// major opcodes of RV32I, bits [6:0]
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111,
		SYS   = 7'b1110011
	} opcode_t;

	// SUB, SRA and the immediate forms reuse these codes
	typedef enum logic [2:0] {
		ADD  = 3'b000,
		SLL  = 3'b001,
		SLT  = 3'b010,
		SLTU = 3'b011,
		XOR  = 3'b100,
		SRL  = 3'b101,
		OR   = 3'b110,
		AND  = 3'b111
	} funct3_t;

	// M extension, selected by funct3 when funct7 is M_INSTR
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} md_op_t;

	typedef enum logic {
		logical    = 1'b0,
		arithmetic = 1'b1
	} shift_type_t;

	parameter logic [6:0] M_INSTR = 7'b0000001;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} instr_t;

	// decoded instruction plus its operands
	typedef struct packed {
		instr_t instr;
		data_t  a_in;
		data_t  b_in; // already the extended imm for LUI, AUIPC, JAL, JALR, LOAD, STORE
	} issue_t;

	typedef struct packed {
		data_t c_out;
		logic  rd_wr;
	} result_t;

	// one request to the shared multiply/divide unit
	typedef struct packed {
		md_op_t op;
		data_t  a;
		data_t  b;
	} md_req_t;

	// I-type immediate, sign extended from bit 31
	function automatic data_t get_imm(input instr_t instr);
		return {{(XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};
	endfunction

endpackage

// File: hdl/alu.sv
module alu (
	input  rv_pkg::instr_t instr,
	input  rv_pkg::data_t  a_in,
	input  rv_pkg::data_t  b_in,

	output rv_pkg::data_t  c_out,
	output logic           rd_wr
);

	rv_pkg::opcode_t     opcode;
	rv_pkg::funct3_t     funct3;
	rv_pkg::shift_type_t shift_type;
	logic [4:0]          shamt;
	logic [4:0]          shift_amt;
	logic                sub_func;
	rv_pkg::data_t       opnd_b;

	rv_pkg::data_t and_result;
	rv_pkg::data_t or_result;
	rv_pkg::data_t xor_result;
	rv_pkg::data_t set_result;
	rv_pkg::data_t shift_result;
	rv_pkg::data_t add_sub_result;

	logic set_signed_flag;
	logic set_unsigned_flag;
	logic set_flag;

	always_comb begin : decode
		opcode     = instr.opcode;
		funct3     = instr.funct3;
		shamt      = instr.rs2;
		shift_type = rv_pkg::shift_type_t'(instr.funct7[5]); // instr bit 30
		sub_func   = (opcode == rv_pkg::R) & instr.funct7[5];
		opnd_b     = (opcode == rv_pkg::I) ? rv_pkg::get_imm(instr) : b_in; // imm or rs2
		shift_amt  = (opcode == rv_pkg::R) ? b_in[4:0] : shamt;
	end

	always_comb begin : logic_ops
		and_result = a_in & opnd_b;
		or_result  = a_in | opnd_b;
		xor_result = a_in ^ opnd_b;
	end

	always_comb begin : shifter
		unique case (funct3)
			rv_pkg::SLL: shift_result = a_in << shift_amt;
			rv_pkg::SRL: begin
				if (shift_type == rv_pkg::arithmetic)
					shift_result = $signed(a_in) >>> shift_amt; // sign fill
				else
					shift_result = a_in >> shift_amt;
			end
			default:     shift_result = '0;
		endcase
	end

	// one adder for ADD/SUB and all the address and link sums
	always_comb begin : add_suber
		add_sub_result = sub_func ? (a_in - opnd_b) : (a_in + opnd_b);
	end

	always_comb begin : seter
		set_signed_flag   = $signed(a_in) < $signed(opnd_b);
		set_unsigned_flag = a_in < opnd_b;
		set_flag          = (funct3 == rv_pkg::SLTU) ? set_unsigned_flag : set_signed_flag;
		set_result        = {{(rv_pkg::XLEN-1){1'b0}}, set_flag};
	end

	always_comb begin : output_sel
		c_out = '0;
		rd_wr = 1'b0;
		unique case (opcode)
			rv_pkg::R,
			rv_pkg::I: begin
				rd_wr = 1'b1;
				unique case (funct3)
					rv_pkg::ADD:  c_out = add_sub_result; // SUB too
					rv_pkg::AND:  c_out = and_result;
					rv_pkg::OR:   c_out = or_result;
					rv_pkg::XOR:  c_out = xor_result;
					rv_pkg::SLT:  c_out = set_result;
					rv_pkg::SLTU: c_out = set_result;
					rv_pkg::SLL:  c_out = shift_result;
					rv_pkg::SRL:  c_out = shift_result; // SRA too
					default:      c_out = '0;
				endcase
			end

			rv_pkg::LUI: begin
				c_out = b_in; // upper imm comes in pre-shifted
				rd_wr = 1'b1;
			end

			rv_pkg::AUIPC,
			rv_pkg::JAL,
			rv_pkg::JALR,
			rv_pkg::LOAD: begin
				c_out = add_sub_result;
				rd_wr = 1'b1;
			end

			rv_pkg::STORE: begin
				c_out = add_sub_result; // address only, nothing to write back
				rd_wr = 1'b0;
			end

			default: begin // B, MEM, SYS
				c_out = '0;
				rd_wr = 1'b0;
			end
		endcase
	end

endmodule

// File: hdl/exec_lane.sv
module exec_lane (
	input  logic            clk,
	input  logic            rst_n,

	input  logic            issue_valid,
	output logic            issue_ready,
	input  rv_pkg::issue_t  issue,

	output logic            res_valid,
	input  logic            res_ready,
	output rv_pkg::result_t res,

	output logic            md_valid,
	input  logic            md_ready,
	output rv_pkg::md_req_t md_req,
	input  logic            md_done,
	input  rv_pkg::data_t   md_result
);

	typedef enum logic [1:0] {
		IDLE,
		MD_WAIT,
		HOLD
	} state_t;

	state_t        state;
	rv_pkg::data_t alu_out;
	logic          alu_wr;
	logic          accept;
	logic          is_md;

	alu u_alu (
		.instr (issue.instr),
		.a_in  (issue.a_in),
		.b_in  (issue.b_in),
		.c_out (alu_out),
		.rd_wr (alu_wr)
	);

	assign issue_ready = (state == IDLE); // one item in flight per lane
	assign res_valid   = (state == HOLD);
	assign accept      = issue_valid & issue_ready;
	assign is_md       = (issue.instr.opcode == rv_pkg::R) &&
			(issue.instr.funct7 == rv_pkg::M_INSTR);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			md_valid <= 1'b0;
		end else begin
			unique case (state)
				IDLE: begin
					if (accept) begin
						state    <= is_md ? MD_WAIT : HOLD;
						md_valid <= is_md;
					end
				end
				MD_WAIT: begin
					if (md_valid && md_ready)
						md_valid <= 1'b0; // granted, now wait for done
					if (md_done)
						state <= HOLD;
				end
				HOLD: begin
					if (res_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			md_req <= '{rv_pkg::md_op_t'(issue.instr.funct3), issue.a_in, issue.b_in};
			res    <= '{alu_out, alu_wr};
		end else if (state == MD_WAIT && md_done) begin
			res <= '{md_result, 1'b1}; // M results always write rd
		end
	end

endmodule

// File: hdl/md_arbiter.sv
module md_arbiter (
	input  logic            clk,
	input  logic            rst_n,

	input  logic            lane_valid [2],
	output logic            lane_ready [2],
	input  rv_pkg::md_req_t lane_req [2],
	output logic            lane_done [2],
	output rv_pkg::data_t   lane_result [2],

	output logic            start,
	output rv_pkg::md_req_t req,
	input  logic            busy,
	input  logic            done,
	input  rv_pkg::data_t   result
);

	logic last;      // lane granted most recently
	logic owner;     // lane whose op is in the unit
	logic start_q;
	logic sel;
	logic can_grant;

	always_comb begin
		can_grant = !busy && !start_q; // unit raises busy one cycle after start
		if (lane_valid[0] && lane_valid[1])
			sel = ~last; // both pending, rotate
		else
			sel = lane_valid[1];
		start = can_grant && (lane_valid[0] || lane_valid[1]);
		req   = lane_req[sel];
		for (int i = 0; i < 2; i++) begin
			lane_ready[i]  = start && (sel == 1'(i));
			lane_done[i]   = done && (owner == 1'(i));
			lane_result[i] = result;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last    <= 1'b1; // lane 0 wins first
			owner   <= 1'b0;
			start_q <= 1'b0;
		end else begin
			start_q <= start;
			if (start) begin
				last  <= sel;
				owner <= sel;
			end
		end
	end

endmodule

// File: hdl/mult_div.sv
module mult_div #(
	parameter int MD_STEP_CYCLES = 1
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  rv_pkg::md_req_t req,
	output logic            busy,
	output logic            done,
	output rv_pkg::data_t   result
);

	localparam int WAIT_W = (MD_STEP_CYCLES > 1) ? $clog2(MD_STEP_CYCLES) : 1;

	rv_pkg::md_op_t    op_q;
	logic [63:0]       acc;      // product, or remainder:quotient
	logic [63:0]       acc_next;
	rv_pkg::data_t     opnd;     // multiplicand or divisor, absolute
	rv_pkg::data_t     dividend;
	logic              neg_q;
	logic              neg_r;
	logic              div_zero;
	logic              div_ovf;
	logic [4:0]        bit_cnt;
	logic [WAIT_W-1:0] wait_cnt;

	logic          req_div;
	logic          a_neg;
	logic          b_neg;
	rv_pkg::data_t a_abs;
	rv_pkg::data_t b_abs;
	logic          op_div;
	logic          step;
	logic          last;
	logic [32:0]   mul_sum;
	logic [33:0]   div_diff;
	logic [63:0]   prod;
	rv_pkg::data_t quot;
	rv_pkg::data_t rem;
	rv_pkg::data_t final_res;

	always_comb begin : req_decode
		req_div = req.op inside {rv_pkg::DIV, rv_pkg::DIVU, rv_pkg::REM, rv_pkg::REMU};
		a_neg   = req.a[31] && (req.op inside {rv_pkg::MULH, rv_pkg::MULHSU,
				rv_pkg::DIV, rv_pkg::REM});
		b_neg   = req.b[31] && (req.op inside {rv_pkg::MULH, rv_pkg::DIV, rv_pkg::REM});
		a_abs   = a_neg ? -req.a : req.a;
		b_abs   = b_neg ? -req.b : req.b;
	end

	always_comb begin : datapath
		op_div   = op_q inside {rv_pkg::DIV, rv_pkg::DIVU, rv_pkg::REM, rv_pkg::REMU};
		step     = busy && (wait_cnt == '0);
		last     = step && (bit_cnt == 5'd31);
		mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opnd} : 33'd0); // add then shift
		div_diff = {1'b0, acc[63:31]} - {2'b0, opnd};                    // trial subtract
		if (op_div)
			acc_next = div_diff[33] ? {acc[62:0], 1'b0} : {div_diff[31:0], acc[30:0], 1'b1};
		else
			acc_next = {mul_sum, acc[31:1]};

		prod = neg_q ? -acc_next : acc_next;
		quot = neg_q ? -acc_next[31:0] : acc_next[31:0];
		rem  = neg_r ? -acc_next[63:32] : acc_next[63:32]; // remainder takes dividend sign
		if (div_zero) begin
			quot = '1;
			rem  = dividend;
		end else if (div_ovf) begin
			quot = dividend; // -2^31 / -1
			rem  = '0;
		end
		unique case (op_q)
			rv_pkg::MUL:       final_res = prod[31:0];
			rv_pkg::DIV,
			rv_pkg::DIVU:      final_res = quot;
			rv_pkg::REM,
			rv_pkg::REMU:      final_res = rem;
			default:           final_res = prod[63:32]; // MULH*
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			bit_cnt  <= '0;
			wait_cnt <= '0;
		end else begin
			done <= last;
			if (!busy) begin
				if (start) begin
					busy     <= 1'b1;
					bit_cnt  <= '0;
					wait_cnt <= WAIT_W'(MD_STEP_CYCLES - 1);
				end
			end else if (!step) begin
				wait_cnt <= wait_cnt - 1'b1;
			end else begin
				bit_cnt  <= bit_cnt + 1'b1;
				wait_cnt <= WAIT_W'(MD_STEP_CYCLES - 1);
				if (last)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			op_q     <= req.op;
			neg_q    <= a_neg ^ b_neg;
			neg_r    <= a_neg;
			dividend <= req.a;
			div_zero <= req_div && (req.b == '0);
			div_ovf  <= (req.op inside {rv_pkg::DIV, rv_pkg::REM}) &&
					(req.a == 32'h8000_0000) && (req.b == '1);
			acc      <= {32'b0, req_div ? a_abs : b_abs};
			opnd     <= req_div ? b_abs : a_abs;
		end else if (step) begin
			acc <= acc_next;
			if (last)
				result <= final_res;
		end
	end

endmodule

// File: hdl/exec_top.sv
module exec_top #(
	parameter int MD_STEP_CYCLES = 1
) (
	input  logic            clk,
	input  logic            rst_n,

	input  logic            issue_valid [2],
	output logic            issue_ready [2],
	input  rv_pkg::issue_t  issue [2],

	output logic            res_valid [2],
	input  logic            res_ready [2],
	output rv_pkg::result_t res [2]
);

	logic            md_valid [2];
	logic            md_ready [2];
	rv_pkg::md_req_t md_req [2];
	logic            md_done [2];
	rv_pkg::data_t   md_result [2];

	logic            md_start;
	rv_pkg::md_req_t md_cmd;
	logic            md_busy;
	logic            md_fin;
	rv_pkg::data_t   md_out;

	for (genvar g = 0; g < 2; g++) begin : g_lane
		exec_lane u_lane (
			.clk         (clk),
			.rst_n       (rst_n),
			.issue_valid (issue_valid[g]),
			.issue_ready (issue_ready[g]),
			.issue       (issue[g]),
			.res_valid   (res_valid[g]),
			.res_ready   (res_ready[g]),
			.res         (res[g]),
			.md_valid    (md_valid[g]),
			.md_ready    (md_ready[g]),
			.md_req      (md_req[g]),
			.md_done     (md_done[g]),
			.md_result   (md_result[g])
		);
	end

	md_arbiter u_arb (
		.clk         (clk),
		.rst_n       (rst_n),
		.lane_valid  (md_valid),
		.lane_ready  (md_ready),
		.lane_req    (md_req),
		.lane_done   (md_done),
		.lane_result (md_result),
		.start       (md_start),
		.req         (md_cmd),
		.busy        (md_busy),
		.done        (md_fin),
		.result      (md_out)
	);

	// shared by both lanes
	mult_div #(
		.MD_STEP_CYCLES (MD_STEP_CYCLES)
	) u_md (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (md_start),
		.req    (md_cmd),
		.busy   (md_busy),
		.done   (md_fin),
		.result (md_out)
	);

endmodule

// File: verif/exec_vectors.svh
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// columns: lane, name, funct7, rs2, funct3, opcode, a_in, b_in, expected c_out, expected rd_wr
// I-type immediates are {funct7, rs2}, and immediate shifts take shamt from rs2
task automatic load_vectors();
	// lane 0 opens with an M op, both lanes hit the unit on the same cycle
	add_vec(0, "div_neg", 7'h01, 5'd0, rv_pkg::DIV, rv_pkg::R, -20, 3, -6, 1);
	add_vec(0, "add", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::R, 5, 7, 12, 1);
	add_vec(0, "sub", 7'h20, 5'd0, rv_pkg::ADD, rv_pkg::R, 3, 5, -2, 1);
	add_vec(0, "and", 7'h00, 5'd0, rv_pkg::AND, rv_pkg::R, 'hF0F0F0F0, 'h0FF00FF0, 'h00F000F0, 1);
	add_vec(0, "or", 7'h00, 5'd0, rv_pkg::OR, rv_pkg::R, 'hF0F0F0F0, 'h0FF00FF0, 'hFFF0FFF0, 1);
	add_vec(0, "xor", 7'h00, 5'd0, rv_pkg::XOR, rv_pkg::R, 'hF0F0F0F0, 'h0FF00FF0, 'hFF00FF00, 1);
	add_vec(0, "slt_neg", 7'h00, 5'd0, rv_pkg::SLT, rv_pkg::R, -1, 1, 1, 1);
	add_vec(0, "sltu_neg", 7'h00, 5'd0, rv_pkg::SLTU, rv_pkg::R, -1, 1, 0, 1);
	add_vec(0, "sll_0", 7'h00, 5'd0, rv_pkg::SLL, rv_pkg::R, 'h12345678, 'h20, 'h12345678, 1);
	add_vec(0, "sll_31", 7'h00, 5'd0, rv_pkg::SLL, rv_pkg::R, 3, 31, 'h80000000, 1);
	add_vec(0, "srl_31", 7'h00, 5'd0, rv_pkg::SRL, rv_pkg::R, 'h80000000, 31, 1, 1);
	add_vec(0, "sra_31", 7'h20, 5'd0, rv_pkg::SRL, rv_pkg::R, 'h80000000, 31, -1, 1);
	add_vec(0, "sra_0", 7'h20, 5'd0, rv_pkg::SRL, rv_pkg::R, 'h80000000, 0, 'h80000000, 1);
	add_vec(0, "lui", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::LUI, 0, 'h12345000, 'h12345000, 1);
	add_vec(0, "auipc", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::AUIPC, 'h1000, 'hFFFFF000, 0, 1);
	add_vec(0, "jal", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::JAL, 'h100, 4, 'h104, 1);
	add_vec(0, "store", 7'h00, 5'd0, rv_pkg::SLT, rv_pkg::STORE, 'h2000, -4, 'h1FFC, 0);
	add_vec(0, "mulh", 7'h01, 5'd0, rv_pkg::MULH, rv_pkg::R, 'h80000000, 'h80000000, 'h40000000, 1);
	add_vec(0, "rem_zero", 7'h01, 5'd0, rv_pkg::REM, rv_pkg::R, 10, 0, 10, 1);
	add_vec(0, "div_ovf", 7'h01, 5'd0, rv_pkg::DIV, rv_pkg::R, 'h80000000, -1, 'h80000000, 1);
	add_vec(0, "beq", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::B, 1, 1, 0, 0);

	// lane 1 waits behind lane 0 for its first M op
	add_vec(1, "mul", 7'h01, 5'd0, rv_pkg::MUL, rv_pkg::R, 7, -3, -21, 1);
	add_vec(1, "addi", 7'h7F, 5'h1F, rv_pkg::ADD, rv_pkg::I, 16, 0, 15, 1);
	add_vec(1, "slti_neg", 7'h7F, 5'h1F, rv_pkg::SLT, rv_pkg::I, -2, 0, 1, 1);
	add_vec(1, "sltiu_neg", 7'h7F, 5'h1F, rv_pkg::SLTU, rv_pkg::I, -2, 0, 1, 1);
	add_vec(1, "andi", 7'h00, 5'h0F, rv_pkg::AND, rv_pkg::I, 'h12345678, 0, 8, 1);
	add_vec(1, "ori", 7'h40, 5'h00, rv_pkg::OR, rv_pkg::I, 'h55, 0, 'hFFFFF855, 1);
	add_vec(1, "xori", 7'h7F, 5'h1F, rv_pkg::XOR, rv_pkg::I, 'h0000FFFF, 0, 'hFFFF0000, 1);
	add_vec(1, "slli_31", 7'h00, 5'd31, rv_pkg::SLL, rv_pkg::I, 1, 0, 'h80000000, 1);
	add_vec(1, "srai_31", 7'h20, 5'd31, rv_pkg::SRL, rv_pkg::I, 'h80000000, 0, -1, 1);
	add_vec(1, "srli_0", 7'h00, 5'd0, rv_pkg::SRL, rv_pkg::I, 'h80000000, 0, 'h80000000, 1);
	add_vec(1, "jalr", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::JALR, 'h3000, 8, 'h3008, 1);
	add_vec(1, "load", 7'h00, 5'd0, rv_pkg::SLT, rv_pkg::LOAD, 'h4000, -16, 'h3FF0, 1);
	add_vec(1, "mulhsu", 7'h01, 5'd0, rv_pkg::MULHSU, rv_pkg::R, -1, -1, -1, 1);
	add_vec(1, "mulhu", 7'h01, 5'd0, rv_pkg::MULHU, rv_pkg::R, -1, -1, 'hFFFFFFFE, 1);
	add_vec(1, "divu", 7'h01, 5'd0, rv_pkg::DIVU, rv_pkg::R, -1, 16, 'h0FFFFFFF, 1);
	add_vec(1, "remu", 7'h01, 5'd0, rv_pkg::REMU, rv_pkg::R, 100, 7, 2, 1);
	add_vec(1, "rem_neg", 7'h01, 5'd0, rv_pkg::REM, rv_pkg::R, -20, 3, -2, 1);
	add_vec(1, "divu_zero", 7'h01, 5'd0, rv_pkg::DIVU, rv_pkg::R, 5, 0, -1, 1);
	add_vec(1, "rem_ovf", 7'h01, 5'd0, rv_pkg::REM, rv_pkg::R, 'h80000000, -1, 0, 1);
	add_vec(1, "sys", 7'h00, 5'd0, rv_pkg::ADD, rv_pkg::SYS, 5, 6, 0, 0);
endtask

`endif

// File: verif/exec_tb.sv
module exec_tb;

	localparam int MD_STEPS     = 2;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DLY    = 2;

	logic            clk = 1'b0;
	logic            rst_n;
	logic            issue_valid [2];
	logic            issue_ready [2];
	rv_pkg::issue_t  issue [2];
	logic            res_valid [2];
	logic            res_ready [2] = '{1'b0, 1'b0};
	rv_pkg::result_t res [2];

	string           vec_name [$];
	rv_pkg::issue_t  vec_issue [$];
	rv_pkg::result_t vec_exp [$];
	logic            vec_md [$];
	int              lane_idx [2][$]; // table indices per lane, in issue order

	logic md_pending [2]; // lane has an M op issued and its result not yet taken
	logic overlap_seen;
	int   seed = 9527;
	int   cycles = 0;
	int   timeout_limit;

	exec_top #(
		.MD_STEP_CYCLES (MD_STEPS)
	) DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue       (issue),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res         (res)
	);

	`include "exec_vectors.svh"

	always #20 clk = ~clk;

	always @(posedge clk) begin
		#DRIVE_DLY;
		res_ready[0] = ($random(seed) % 4) != 0; // ready about three cycles in four
		res_ready[1] = ($random(seed) % 4) != 0;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("timeout, the results did not arrive within %0d cycles", timeout_limit);
			report_fail();
		end
	end

	task automatic report_fail();
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input rv_pkg::data_t exp, input rv_pkg::data_t act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			report_fail();
		end
	endtask

	task automatic check_wr(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERROR %s: expected rd_wr %b, actual %b", name, exp, act);
			report_fail();
		end
	endtask

	task automatic add_vec(input int lane, input string name, input logic [6:0] funct7,
			input logic [4:0] rs2, input logic [2:0] funct3, input rv_pkg::opcode_t opcode,
			input rv_pkg::data_t a, input rv_pkg::data_t b, input rv_pkg::data_t c, input int wr);
		rv_pkg::issue_t  iss;
		rv_pkg::result_t exp_res;
		iss.instr     = {funct7, rs2, 5'd1, funct3, 5'd2, opcode}; // rs1 and rd are don't care
		iss.a_in      = a;
		iss.b_in      = b;
		exp_res.c_out = c;
		exp_res.rd_wr = (wr != 0);
		if (lane == 0)
			lane_idx[0].push_back(vec_name.size());
		else
			lane_idx[1].push_back(vec_name.size());
		vec_name.push_back(name);
		vec_issue.push_back(iss);
		vec_exp.push_back(exp_res);
		vec_md.push_back((opcode == rv_pkg::R) && (funct7 == rv_pkg::M_INSTR));
	endtask

	task automatic drive_lane(input bit l);
		int k;
		for (int n = 0; n < lane_idx[l].size(); n++) begin
			k = lane_idx[l][n];
			issue[l]       = vec_issue[k];
			issue_valid[l] = 1'b1;
			do
				@(negedge clk);
			while (!issue_ready[l]);
			@(posedge clk); // transfer edge
			md_pending[l] = vec_md[k];
			#DRIVE_DLY;
		end
		issue_valid[l] = 1'b0;
	endtask

	task automatic check_lane(input bit l);
		int              n;
		int              k;
		logic            holding;
		rv_pkg::result_t held;
		n       = 0;
		holding = 1'b0;
		held    = '0;
		while (n < lane_idx[l].size()) begin
			@(negedge clk);
			if (holding && (!res_valid[l] || res[l] !== held)) begin
				$display("lane %0d dropped or changed its result while res_ready was low", l);
				report_fail();
			end
			holding = res_valid[l] && !res_ready[l];
			held    = res[l];
			if (res_valid[l] && res_ready[l]) begin
				k = lane_idx[l][n];
				check_data(vec_name[k], vec_exp[k].c_out, res[l].c_out);
				check_wr(vec_name[k], vec_exp[k].rd_wr, res[l].rd_wr);
				if (!vec_md[k] && md_pending[!l] && !res_valid[!l])
					overlap_seen = 1'b1; // ALU work went past the other lane's M op
				n++;
				@(posedge clk);
				md_pending[l] = 1'b0;
			end
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		issue_valid  = '{1'b0, 1'b0};
		issue        = '{'0, '0};
		md_pending   = '{1'b0, 1'b0};
		overlap_seen = 1'b0;
		load_vectors();
		timeout_limit = vec_name.size() * 40 + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		fork
			drive_lane(1'b0);
			drive_lane(1'b1);
			check_lane(1'b0);
			check_lane(1'b1);
		join
		repeat (2) @(negedge clk);
		if (overlap_seen && !res_valid[0] && !res_valid[1]) begin
			$display("Test passed");
			$finish;
		end else begin
			if (!overlap_seen)
				$display("no ALU result finished while the other lane waited on the M unit");
			else
				$display("a lane raised res_valid after its last expected result");
			report_fail();
		end
	end

endmodule

// File: vlog.f
+incdir+verif
hdl/rv_pkg.sv
hdl/alu.sv
hdl/exec_lane.sv
hdl/md_arbiter.sv
hdl/mult_div.sv
hdl/exec_top.sv
verif/exec_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build exec_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module exec_tb -f vlog.f -o exec_sim
	@out=$$(./obj_dir/exec_sim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
